/* logic/wr_fifo2.sv */
/*
 * Two-entry registered valid/ready FIFO
 */
`timescale 1ns/1ps

module wr_fifo2
#(
    parameter int DATA_WIDTH = 8
)
(
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [DATA_WIDTH-1:0]  in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [DATA_WIDTH-1:0]  out_data
);

    logic [DATA_WIDTH-1:0]  mem [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic                   enq;
    logic                   deq;

    // Both sides look only at the occupancy count, never at each other
    assign in_ready = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data = mem[rd_ptr];

    assign enq = in_valid && in_ready;
    assign deq = out_valid && out_ready;

    // Storage, written into the free slot so the head entry never moves
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (enq)
                wr_ptr <= ~wr_ptr;
            if (deq)
                rd_ptr <= ~rd_ptr;
            // Simultaneous enqueue and dequeue leaves the count alone
            count <= count + {1'b0, enq} - {1'b0, deq};
        end
    end

    // A stalled head entry stays valid and unchanged until it is taken
    head_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("FIFO head changed while stalled");

endmodule

/* logic/wr_req_canon.sv */
/*
 * Write request canonicalizer: opcode, dword length, byte enables and aligned address
 */
`timescale 1ns/1ps

module wr_req_canon
#(
    parameter int DATA_WIDTH = 221
)
(
    input  logic                              req_valid,
    output logic                              req_ready,
    input  wr_tlp_pkg::t_addr                 req_addr,
    input  wr_tlp_pkg::t_tag                  req_tag,
    input  logic [wr_tlp_pkg::LINE_BITS-1:0]  req_payload,
    input  logic                              req_byte_range,
    input  wr_tlp_pkg::t_byte_idx             req_byte_start,
    input  wr_tlp_pkg::t_byte_len             req_byte_len,
    output logic                              canon_valid,
    input  logic                              canon_ready,
    output logic [DATA_WIDTH-1:0]             canon_data
);

    import wr_tlp_pkg::*;

    localparam int IDX_W = $bits(t_byte_idx);
    // Wide enough for start + len + 3 without overflow
    localparam int SUM_W = IDX_W + 2;

    t_byte_idx           start_idx;
    t_byte_idx           end_idx;
    t_byte_len           byte_len;
    logic [SUM_W-1:0]    range_end;
    logic [SUM_W-1:0]    dw_span;
    t_fmttype            fmttype;
    t_dword_len          dword_len;
    t_be                 first_mask;
    t_be                 first_be;
    t_be                 last_be;
    t_dword_idx          shift_dw;
    t_addr               tlp_addr;

    // The stage is purely combinational, so the handshake passes straight through
    assign canon_valid = req_valid;
    assign req_ready = canon_ready;

    // A full-line write is the byte range 0..LINE_BYTES-1
    always_comb
    begin
        if (req_byte_range)
        begin
            start_idx = req_byte_start;
            byte_len = req_byte_len;
        end
        else
        begin
            start_idx = '0;
            byte_len = t_byte_len'(LINE_BYTES);
        end
    end

    // One past the last byte, and the last byte itself
    assign range_end = SUM_W'(start_idx) + SUM_W'(byte_len);
    assign end_idx = t_byte_idx'(range_end - 1'b1);

    // MWr64 is only legal when the address does not fit in 32 bits
    assign fmttype = (|req_addr[63:32]) ? FMT_MEM_WRITE64 : FMT_MEM_WRITE32;

    // Count dwords touched, including the leading unused bytes of the first one
    assign dw_span = SUM_W'(start_idx[1:0]) + SUM_W'(byte_len) + SUM_W'(3);
    assign dword_len = t_dword_len'(dw_span >> 2);

    // First dword enables, which also close the range when it is shorter than a dword
    always_comb
    begin
        first_mask = 4'hf;
        if (byte_len < 4)
        begin
            case (byte_len[1:0])
                2'b01: first_mask = 4'h1;
                2'b10: first_mask = 4'h3;
                2'b11: first_mask = 4'h7;
                default: first_mask = 4'h0;
            endcase
        end
        first_be = t_be'(first_mask << start_idx[1:0]);
    end

    // Last dword enables, which PCIe requires to be zero for a one-dword payload
    always_comb
    begin
        last_be = 4'h0;
        if (start_idx[IDX_W-1:2] != end_idx[IDX_W-1:2])
        begin
            case (end_idx[1:0])
                2'b00: last_be = 4'h1;
                2'b01: last_be = 4'h3;
                2'b10: last_be = 4'h7;
                default: last_be = 4'hf;
            endcase
        end
    end

    // The TLP starts at the dword holding the first byte
    assign shift_dw = start_idx[IDX_W-1:2];
    assign tlp_addr = {req_addr[63:IDX_W], shift_dw, 2'b00};

    // Field order here must match the unpacking in the TLP former
    assign canon_data = {fmttype, dword_len, first_be, last_be, tlp_addr, shift_dw,
                         req_tag, req_payload};

    // Byte ranges must be non-empty and stay inside one line
    range_legal_a: assert final (!req_valid || !req_byte_range ||
                                 (req_byte_len != '0 && range_end <= LINE_BYTES))
        else $error("illegal byte range start %0d len %0d", req_byte_start, req_byte_len);

endmodule

/* logic/wr_tlp_former.sv */
/*
 * TLP former: payload shift, keep mask and the registered TLP output
 */
`timescale 1ns/1ps

module wr_tlp_former
#(
    parameter int DATA_WIDTH = 221
)
(
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  logic [DATA_WIDTH-1:0]              in_data,
    output logic                               tlp_valid,
    output wr_tlp_pkg::t_fmttype               tlp_fmttype,
    output wr_tlp_pkg::t_dword_len             tlp_length,
    output wr_tlp_pkg::t_addr                  tlp_addr,
    output wr_tlp_pkg::t_tag                   tlp_tag,
    output wr_tlp_pkg::t_be                    tlp_first_be,
    output wr_tlp_pkg::t_be                    tlp_last_be,
    output logic [wr_tlp_pkg::LINE_BITS-1:0]   tlp_data,
    output logic [wr_tlp_pkg::LINE_BYTES-1:0]  tlp_keep,
    input  logic                               tlp_ready
);

    import wr_tlp_pkg::*;

    // ========================================
    // Unpack the canonical request
    // ========================================

    logic [$bits(t_fmttype)-1:0]  in_fmt_bits;
    t_dword_len                   in_length;
    t_be                          in_first_be;
    t_be                          in_last_be;
    t_addr                        in_addr;
    t_dword_idx                   in_shift;
    t_tag                         in_tag;
    logic [LINE_BITS-1:0]         in_payload;

    logic [LINE_BITS-1:0]         shifted_payload;
    logic [LINE_DWORDS-1:0]       keep_dw;
    logic [LINE_BYTES-1:0]        keep_bytes;
    logic                         load;

    // Same field order as the canonicalizer packs them
    assign {in_fmt_bits, in_length, in_first_be, in_last_be, in_addr, in_shift,
            in_tag, in_payload} = in_data;

    // ========================================
    // Payload alignment and keep mask
    // ========================================

    // Move the first written dword down to bit 0, filling the top with zeros.
    // In full-line mode the shift count is zero and the line passes unchanged
    assign shifted_payload = in_payload >> {in_shift, 5'b0};

    // One bit per dword with the low length bits set
    assign keep_dw = ~({LINE_DWORDS{1'b1}} << in_length);

    // Expand each dword bit to its four bytes
    always_comb
    begin
        for (int d = 0; d < LINE_DWORDS; d++)
        begin
            keep_bytes[d*4 +: 4] = {4{keep_dw[d]}};
        end
    end

    // ========================================
    // Output register
    // ========================================

    // The register takes a new TLP when the old one leaves or it is empty
    assign load = tlp_ready || !tlp_valid;
    assign in_ready = load;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tlp_valid <= 1'b0;
        end
        else if (load)
        begin
            tlp_valid <= in_valid;
        end
    end

    // Header and payload registers load on the same condition as tlp_valid
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            tlp_fmttype <= t_fmttype'(in_fmt_bits);
            tlp_length <= in_length;
            tlp_addr <= in_addr;
            tlp_tag <= in_tag;
            tlp_first_be <= in_first_be;
            tlp_last_be <= in_last_be;
            tlp_data <= shifted_payload;
            tlp_keep <= keep_bytes;
        end
    end

    // A TLP that is not taken must be offered again unchanged
    tlp_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
        tlp_valid && !tlp_ready |=> tlp_valid &&
            $stable({tlp_fmttype, tlp_length, tlp_addr, tlp_tag, tlp_first_be,
                     tlp_last_be, tlp_data, tlp_keep}))
        else $error("TLP changed under back-pressure");

endmodule

/* logic/wr_tlp_gen.sv */
/*
 * Memory-write TLP generator top: request path and completion-to-response path
 */
`timescale 1ns/1ps

module wr_tlp_gen
#(
    // Canonical request word, in the order the canonicalizer packs it
    parameter int FIFO_WIDTH_REQ = $bits(wr_tlp_pkg::t_fmttype) +
                                   $bits(wr_tlp_pkg::t_dword_len) +
                                   2 * $bits(wr_tlp_pkg::t_be) +
                                   $bits(wr_tlp_pkg::t_addr) +
                                   $bits(wr_tlp_pkg::t_dword_idx) +
                                   $bits(wr_tlp_pkg::t_tag) +
                                   wr_tlp_pkg::LINE_BITS,
    // Completions carry only the tag
    parameter int FIFO_WIDTH_CPL = $bits(wr_tlp_pkg::t_tag)
)
(
    input  logic                               clk,
    input  logic                               reset_n,

    // Write requests
    input  logic                               req_valid,
    output logic                               req_ready,
    input  wr_tlp_pkg::t_addr                  req_addr,
    input  wr_tlp_pkg::t_tag                   req_tag,
    input  logic [wr_tlp_pkg::LINE_BITS-1:0]   req_payload,
    input  logic                               req_byte_range,
    input  wr_tlp_pkg::t_byte_idx              req_byte_start,
    input  wr_tlp_pkg::t_byte_len              req_byte_len,

    // Outgoing memory-write TLPs
    output logic                               tlp_valid,
    input  logic                               tlp_ready,
    output wr_tlp_pkg::t_fmttype               tlp_fmttype,
    output wr_tlp_pkg::t_dword_len             tlp_length,
    output wr_tlp_pkg::t_addr                  tlp_addr,
    output wr_tlp_pkg::t_tag                   tlp_tag,
    output wr_tlp_pkg::t_be                    tlp_first_be,
    output wr_tlp_pkg::t_be                    tlp_last_be,
    output logic [wr_tlp_pkg::LINE_BITS-1:0]   tlp_data,
    output logic [wr_tlp_pkg::LINE_BYTES-1:0]  tlp_keep,

    // Write completions from the link side
    input  logic                               cpl_valid,
    output logic                               cpl_ready,
    input  wr_tlp_pkg::t_tag                   cpl_tag,

    // Write responses back to the requester
    output logic                               rsp_valid,
    input  logic                               rsp_ready,
    output wr_tlp_pkg::t_tag                   rsp_tag
);

    // ========================================
    // Request path
    // ========================================

    logic                       canon_valid;
    logic                       canon_ready;
    logic [FIFO_WIDTH_REQ-1:0]  canon_data;
    logic                       fifo_valid;
    logic                       fifo_ready;
    logic [FIFO_WIDTH_REQ-1:0]  fifo_data;

    wr_req_canon #(.DATA_WIDTH(FIFO_WIDTH_REQ)) canon0 (
        .req_valid, .req_ready, .req_addr, .req_tag, .req_payload,
        .req_byte_range, .req_byte_start, .req_byte_len,
        .canon_valid, .canon_ready, .canon_data
    );

    // Buffers requests so the former's register is the only output timing stage
    wr_fifo2 #(.DATA_WIDTH(FIFO_WIDTH_REQ)) req_fifo0 (
        .clk, .reset_n,
        .in_valid(canon_valid), .in_ready(canon_ready), .in_data(canon_data),
        .out_valid(fifo_valid), .out_ready(fifo_ready), .out_data(fifo_data)
    );

    wr_tlp_former #(.DATA_WIDTH(FIFO_WIDTH_REQ)) former0 (
        .clk, .reset_n,
        .in_valid(fifo_valid), .in_ready(fifo_ready), .in_data(fifo_data),
        .tlp_valid, .tlp_fmttype, .tlp_length, .tlp_addr, .tlp_tag,
        .tlp_first_be, .tlp_last_be, .tlp_data, .tlp_keep, .tlp_ready
    );

    // ========================================
    // Completion path
    // ========================================

    // Each completion comes back as a response with the same tag, in order
    wr_fifo2 #(.DATA_WIDTH(FIFO_WIDTH_CPL)) cpl_fifo0 (
        .clk, .reset_n,
        .in_valid(cpl_valid), .in_ready(cpl_ready), .in_data(cpl_tag),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_tag)
    );

endmodule

/* logic/wr_tlp_pkg.sv */
/*
 * Line geometry, index and header-field types and the write opcode
 */
package wr_tlp_pkg;

    // ========================================
    // Line geometry
    // ========================================

    // One payload line is the unit of every write request
    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS = 8 * LINE_BYTES;
    localparam int LINE_DWORDS = LINE_BYTES / 4;

    // Width of the tag that travels with a request and its response
    localparam int TAG_WIDTH = 8;

    // ========================================
    // Index and length types
    // ========================================

    // Byte position inside a line
    typedef logic [$clog2(LINE_BYTES)-1:0] t_byte_idx;

    // Byte count 1..LINE_BYTES, so one bit wider than an index
    typedef logic [$clog2(LINE_BYTES):0] t_byte_len;

    // Dword position inside a line, used as the payload shift count
    typedef logic [$clog2(LINE_DWORDS)-1:0] t_dword_idx;

    // TLP length field in dwords, must be able to hold LINE_DWORDS itself
    typedef logic [$clog2(LINE_DWORDS + 1)-1:0] t_dword_len;

    // ========================================
    // Header fields
    // ========================================

    // Byte enables cover the four bytes of the first or last dword
    typedef logic [3:0] t_be;
    typedef logic [TAG_WIDTH-1:0] t_tag;
    typedef logic [63:0] t_addr;

    // PCIe fmt/type codes for memory writes with 3DW and 4DW headers
    typedef enum logic [7:0] {
        FMT_MEM_WRITE32 = 8'h40,
        FMT_MEM_WRITE64 = 8'h60
    } t_fmttype;

endpackage

/* tb.f */
+incdir+test
logic/wr_tlp_pkg.sv
logic/wr_req_canon.sv
logic/wr_fifo2.sv
logic/wr_tlp_former.sv
logic/wr_tlp_gen.sv
test/wr_tlp_tb.sv

/* test/wr_tlp_ref.svh */
/*
 * Reference TLP model, typed compare tasks for TLPs and responses, check counters
 */
`ifndef WR_TLP_REF_SVH
`define WR_TLP_REF_SVH

// Running totals of compares over the whole run
int pass_count = 0;
int fail_count = 0;

// One expected TLP, field for field as the DUT drives it
typedef struct packed {
    t_fmttype                fmttype;
    t_dword_len              length;
    t_addr                   addr;
    t_tag                    tag;
    t_be                     first_be;
    t_be                     last_be;
    logic [LINE_BITS-1:0]    data;
    logic [LINE_BYTES-1:0]   keep;
} t_tlp_exp;

// ========================================
// Reference model
// ========================================

// Builds the expected TLP straight from the byte range of a request
function automatic t_tlp_exp ref_tlp(input t_addr addr, input t_tag tag,
                                     input logic [LINE_BITS-1:0] payload,
                                     input logic byte_range, input int byte_start,
                                     input int byte_len);
    t_tlp_exp tlp;
    int start;
    int len;
    int last;
    int mask;
    start = byte_range ? byte_start : 0;
    len = byte_range ? byte_len : LINE_BYTES;
    last = start + len - 1;
    // Any bit above 4 GiB forces the 4DW header
    tlp.fmttype = (addr[63:32] != 0) ? FMT_MEM_WRITE64 : FMT_MEM_WRITE32;
    tlp.length = t_dword_len'((start % 4 + len + 3) / 4);
    mask = (len < 4) ? ((1 << len) - 1) : 15;
    tlp.first_be = t_be'(mask << (start % 4));
    // A single-dword payload has no last dword
    if (start / 4 == last / 4)
        tlp.last_be = 4'b0000;
    else
        tlp.last_be = t_be'((2 << (last % 4)) - 1);
    tlp.addr = (addr & ~t_addr'(LINE_BYTES - 1)) + t_addr'((start / 4) * 4);
    tlp.tag = tag;
    tlp.data = payload >> (32 * (start / 4));
    for (int i = 0; i < LINE_BYTES; i++)
    begin
        tlp.keep[i] = (i < 4 * int'(tlp.length));
    end
    return tlp;
endfunction

// ========================================
// Compare tasks
// ========================================

task automatic check_tlp(input t_tlp_exp exp, input t_fmttype fmttype,
                         input t_dword_len length, input t_addr addr, input t_tag tag,
                         input t_be first_be, input t_be last_be,
                         input logic [LINE_BITS-1:0] data,
                         input logic [LINE_BYTES-1:0] keep);
    t_tlp_exp got;
    got = {fmttype, length, addr, tag, first_be, last_be, data, keep};
    if (got !== exp)
    begin
        $display("CHECK FAILED at %0t: TLP tag %0h got fmt %0h len %0d addr %0h be %0h/%0h",
                 $time, tag, fmttype, length, addr, first_be, last_be);
        $display("    expected fmt %0h len %0d addr %0h tag %0h be %0h/%0h",
                 exp.fmttype, exp.length, exp.addr, exp.tag, exp.first_be, exp.last_be);
        $display("    data got %h exp %h, keep got %h exp %h", data, exp.data, keep, exp.keep);
        fail_count++;
    end
    else
        pass_count++;
endtask

task automatic check_rsp(input t_tag exp_tag, input t_tag tag);
    if (tag !== exp_tag)
    begin
        $display("CHECK FAILED at %0t: response tag %0h, expected %0h", $time, tag, exp_tag);
        fail_count++;
    end
    else
        pass_count++;
endtask

`endif

/* test/wr_tlp_tb.sv */
/*
 * Testbench for the memory-write TLP generator: stimulus, scoreboard and six tests
 */
`timescale 1ns/1ps

module wr_tlp_tb;

    import wr_tlp_pkg::*;

    // Cycles any single wait may take before the run is abandoned
    localparam int WAIT_LIMIT = 2000;
    localparam int DRIVE_DELAY = 10;

    logic                    clk;
    logic                    reset_n;
    logic                    req_valid;
    logic                    req_ready;
    t_addr                   req_addr;
    t_tag                    req_tag;
    logic [LINE_BITS-1:0]    req_payload;
    logic                    req_byte_range;
    t_byte_idx               req_byte_start;
    t_byte_len               req_byte_len;
    logic                    tlp_valid;
    logic                    tlp_ready;
    t_fmttype                tlp_fmttype;
    t_dword_len              tlp_length;
    t_addr                   tlp_addr;
    t_tag                    tlp_tag;
    t_be                     tlp_first_be;
    t_be                     tlp_last_be;
    logic [LINE_BITS-1:0]    tlp_data;
    logic [LINE_BYTES-1:0]   tlp_keep;
    logic                    cpl_valid;
    logic                    cpl_ready;
    t_tag                    cpl_tag;
    logic                    rsp_valid;
    logic                    rsp_ready;
    t_tag                    rsp_tag;

    `include "wr_tlp_ref.svh"

    int        seed = 32'hc7afe1a4;
    t_tlp_exp  exp_tlp_q[$];
    t_tag      exp_rsp_q[$];
    t_tag      next_tag = '0;
    int        stall_count = 0;
    // Back-pressure switches for the two output streams
    logic      tlp_throttle = 1'b0;
    logic      rsp_throttle = 1'b0;

    wr_tlp_gen dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Scoreboard
    // ========================================

    // Handshakes are sampled at the falling edge, where every signal is settled
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (req_valid && req_ready)
                exp_tlp_q.push_back(ref_tlp(req_addr, req_tag, req_payload, req_byte_range,
                                            int'(req_byte_start), int'(req_byte_len)));
            if (req_valid && !req_ready)
                stall_count++;
            if (cpl_valid && cpl_ready)
                exp_rsp_q.push_back(cpl_tag);
        end
    end

    // Output monitor, in order against the queued expectations
    always @(negedge clk)
    begin
        if (reset_n && tlp_valid && tlp_ready)
        begin
            if (exp_tlp_q.size() == 0)
            begin
                $display("unexpected TLP with tag %0h at %0t while no request was outstanding",
                         tlp_tag, $time);
                fail_count++;
            end
            else
                check_tlp(exp_tlp_q.pop_front(), tlp_fmttype, tlp_length, tlp_addr, tlp_tag,
                          tlp_first_be, tlp_last_be, tlp_data, tlp_keep);
        end
        if (reset_n && rsp_valid && rsp_ready)
        begin
            if (exp_rsp_q.size() == 0)
            begin
                $display("unexpected response with tag %0h at %0t while no completion was queued",
                         rsp_tag, $time);
                fail_count++;
            end
            else
                check_rsp(exp_rsp_q.pop_front(), rsp_tag);
        end
    end

    // Ready inputs change shortly after each rising edge, randomly when throttled
    initial
    begin
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            tlp_ready = tlp_throttle ? (($random(seed) & 3) == 0) : 1'b1;
            rsp_ready = rsp_throttle ? (($random(seed) & 1) == 0) : 1'b1;
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t after %0d cycles waiting for %0s", $time, WAIT_LIMIT, what);
        $display("sim failed");
        $finish;
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // Line-aligned address, about half of them above 4 GiB
    function automatic t_addr rand_addr();
        t_addr a;
        a = {$random(seed), $random(seed)};
        if (rand_below(2) == 0)
            a[63:32] = '0;
        return a & ~t_addr'(LINE_BYTES - 1);
    endfunction

    function automatic logic [LINE_BITS-1:0] rand_line();
        logic [LINE_BITS-1:0] line;
        for (int d = 0; d < LINE_DWORDS; d++)
        begin
            line[d*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    // Offers one request and returns just after the edge that takes it
    task automatic send_req(input t_addr addr, input logic byte_range, input int start,
                            input int len);
        int waited;
        req_addr = addr;
        req_tag = next_tag;
        req_payload = rand_line();
        req_byte_range = byte_range;
        req_byte_start = t_byte_idx'(start);
        req_byte_len = t_byte_len'(len);
        req_valid = 1'b1;
        next_tag++;
        waited = 0;
        @(negedge clk);
        while (!req_ready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_on_timeout("the DUT to accept a request");
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b0;
    endtask

    // Kind 0 is a full line, 1 stays inside a dword, 2 spans dwords, 3 picks one
    task automatic send_random_req(input int mode);
        int kind;
        int start;
        int len;
        int off;
        kind = (mode == 3) ? rand_below(3) : mode;
        start = 0;
        len = LINE_BYTES;
        if (kind == 1)
        begin
            off = rand_below(4);
            start = 4 * rand_below(LINE_DWORDS) + off;
            len = 1 + rand_below(4 - off);
        end
        else if (kind == 2)
        begin
            start = rand_below(LINE_BYTES - 4);
            len = 4 + rand_below(LINE_BYTES - start - 3);
        end
        send_req(rand_addr(), kind != 0, start, len);
    endtask

    task automatic send_cpl(input t_tag tag);
        int waited;
        cpl_tag = tag;
        cpl_valid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cpl_ready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_on_timeout("the DUT to accept a completion");
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cpl_valid = 1'b0;
    endtask

    // Waits until every expected TLP and response has been seen
    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_tlp_q.size() != 0 || exp_rsp_q.size() != 0)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_on_timeout(what);
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %0s finished with %0d errors", name, fail_count - fails_before);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int fails_before;
        int stalls_before;
        reset_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_tag = '0;
        req_payload = '0;
        req_byte_range = 1'b0;
        req_byte_start = '0;
        req_byte_len = '0;
        tlp_ready = 1'b1;
        cpl_valid = 1'b0;
        cpl_tag = '0;
        rsp_ready = 1'b1;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        // Idle handshake levels right after reset
        fails_before = fail_count;
        @(negedge clk);
        if (tlp_valid !== 1'b0 || rsp_valid !== 1'b0 || req_ready !== 1'b1 ||
            cpl_ready !== 1'b1)
        begin
            $display("CHECK FAILED at %0t: after reset tlp_valid %b rsp_valid %b req_ready %b",
                     $time, tlp_valid, rsp_valid, req_ready);
            fail_count++;
        end
        else
            pass_count++;
        @(posedge clk);
        #DRIVE_DELAY;
        report_test("reset state", fails_before);

        // Full lines below and above 4 GiB
        fails_before = fail_count;
        send_req(64'h0000_0000_1234_5670, 1'b0, 0, 0);
        send_req(64'h0000_0002_0000_0010, 1'b0, 0, 0);
        repeat (6) send_random_req(0);
        wait_drain("full-line TLPs");
        report_test("full-line writes", fails_before);

        fails_before = fail_count;
        repeat (24) send_random_req(1);
        wait_drain("single-dword TLPs");
        report_test("single-dword ranges", fails_before);

        fails_before = fail_count;
        repeat (200) send_random_req(2);
        wait_drain("multi-dword TLPs");
        report_test("random multi-dword ranges", fails_before);

        // The output is ready one cycle in four, so the request FIFO fills up
        fails_before = fail_count;
        stalls_before = stall_count;
        tlp_throttle = 1'b1;
        repeat (100) send_random_req(3);
        wait_drain("TLPs under back-pressure");
        tlp_throttle = 1'b0;
        if (stall_count == stalls_before)
        begin
            $display("no request was held off while the TLP output was throttled");
            fail_count++;
        end
        report_test("TLP back-pressure", fails_before);

        // Completions and requests run side by side
        fails_before = fail_count;
        rsp_throttle = 1'b1;
        fork
            repeat (40) send_cpl(t_tag'(rand_below(256)));
            repeat (30) send_random_req(3);
        join
        wait_drain("responses and TLPs");
        rsp_throttle = 1'b0;
        report_test("completions to responses", fails_before);

        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
